// ==== core_cfg.svh ====
////////////////////
// fixed constants for the core wrapper glue logic
// settings register map, sync delay, save-state timing
// and the data-table word written after reset
////////////////////

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// settings register addresses on the bridge
`define CFG_ADDR_HIDE_OVERSCAN  32'h0000_0200
`define CFG_ADDR_MASK_EDGES     32'h0000_0204
`define CFG_ADDR_EXTRA_SPRITES  32'h0000_0208
`define CFG_ADDR_PALETTE        32'h0000_020C
`define CFG_ADDR_MULTITAP       32'h0000_0300

// hsync re-timing, in clk_74a cycles
`define CFG_HS_DELAY            7
// save-state busy length
`define CFG_SS_HOLD             2

// data slot index 1 -> table word 1*2+1
`define CFG_DT_SAVE_ADDR        3
`define CFG_DT_SAVE_SIZE        32'h0004_0000

// slot word bit carrying hide_overscan
`define CFG_SLOT_HIDE_BIT       13

`endif

// ==== bridge_pkg.sv ====
////////////////////
// bridge side types
// settings widths, data table and save-state responder states
////////////////////

`default_nettype none

package bridge_pkg;

  // 32-bit bridge bus
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // emulator settings
  typedef logic [1:0] edge_mask_t;
  typedef logic [2:0] palette_t;

  // data table word address
  typedef logic [9:0] dt_addr_t;

  // save-state start responder
  typedef enum logic [1:0] {ss_idle, ss_hold, ss_finish} ss_state_t;

endpackage

`default_nettype wire

// ==== video_pkg.sv ====
////////////////////
// video side types
// pixel word and hsync delay counter
////////////////////

`default_nettype none

package video_pkg;

  // 8 bits each of r, g, b
  typedef logic [23:0] rgb_t;

  // wide enough for the hsync delay count
  typedef logic [2:0] hs_delay_t;

endpackage

`default_nettype wire

// ==== bridge_settings_regs.sv ====
////////////////////
// settings registers written over the bridge
// one write per cycle, outputs update on the next cycle
////////////////////

`default_nettype none

`include "core_cfg.svh"

module bridge_settings_regs (
  input  wire                       clk_74a,
  input  wire                       pll_core_locked,
  input  wire bridge_pkg::bridge_addr_t bridge_addr,
  input  wire                       bridge_wr,
  input  wire bridge_pkg::bridge_data_t bridge_wr_data,
  output logic                      hide_overscan,
  output bridge_pkg::edge_mask_t    mask_vid_edges,
  output logic                      allow_extra_sprites,
  output bridge_pkg::palette_t      selected_palette,
  output logic                      multitap_enabled
);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
    end else if (bridge_wr) begin
      // unlisted addresses fall through, nothing changes
      case (bridge_addr)
        `CFG_ADDR_HIDE_OVERSCAN: hide_overscan       <= bridge_wr_data[0];
        `CFG_ADDR_MASK_EDGES:    mask_vid_edges      <= bridge_wr_data[1:0];
        `CFG_ADDR_EXTRA_SPRITES: allow_extra_sprites <= bridge_wr_data[0];
        // palette index in low 3 bits
        `CFG_ADDR_PALETTE:       selected_palette    <= bridge_wr_data[2:0];
        `CFG_ADDR_MULTITAP:      multitap_enabled    <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== savestate_start_responder.sv ====
////////////////////
// answers a host save-state start request
// ack pulse, busy for CFG_SS_HOLD cycles, then ok until the next start
////////////////////

`default_nettype none

`include "core_cfg.svh"

module savestate_start_responder (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  savestate_start,
  output logic savestate_start_ack,
  output logic savestate_start_busy,
  output logic savestate_start_ok
);

  bridge_pkg::ss_state_t state;
  logic                  start_prev;
  logic [1:0]            hold_cnt;
  logic                  start_rise;

  // rising edge against the registered copy
  assign start_rise = savestate_start & ~start_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state               <= bridge_pkg::ss_idle;
      start_prev          <= 1'b0;
      hold_cnt            <= '0;
      savestate_start_ack <= 1'b0;
    end else begin
      start_prev          <= savestate_start;
      savestate_start_ack <= 1'b0;
      case (state)
        bridge_pkg::ss_hold: begin
          // rises in here are dropped
          if (hold_cnt == '0) begin
            state <= bridge_pkg::ss_finish;
          end else begin
            hold_cnt <= hold_cnt - 2'd1;
          end
        end
        default: begin
          // idle or finish, both accept a new start
          if (start_rise) begin
            state               <= bridge_pkg::ss_hold;
            hold_cnt            <= 2'(`CFG_SS_HOLD - 1);
            savestate_start_ack <= 1'b1;
          end
        end
      endcase
    end
  end

  // levels decoded straight from the state register
  assign savestate_start_busy = (state == bridge_pkg::ss_hold);
  assign savestate_start_ok   = (state == bridge_pkg::ss_finish);

endmodule

`default_nettype wire

// ==== dataslot_status.sv ====
////////////////////
// data slot status
// download-in-progress level, plus the save size word written into the data table
////////////////////

`default_nettype none

`include "core_cfg.svh"

module dataslot_status (
  input  wire                   clk_74a,
  input  wire                   pll_core_locked,
  input  wire                   dataslot_requestwrite,
  input  wire                   dataslot_allcomplete,
  input  wire                   has_save,
  output logic                  ioctl_download,
  output bridge_pkg::dt_addr_t  datatable_addr,
  output logic                  datatable_wren,
  output bridge_pkg::bridge_data_t datatable_data
);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ioctl_download <= 1'b0;
      datatable_addr <= '0;
      datatable_wren <= 1'b0;
      datatable_data <= '0;
    end else begin
      // request wins over completion
      if (dataslot_requestwrite) begin
        ioctl_download <= 1'b1;
      end else if (dataslot_allcomplete) begin
        ioctl_download <= 1'b0;
      end
      // save size write runs every cycle
      datatable_wren <= 1'b1;
      datatable_addr <= bridge_pkg::dt_addr_t'(`CFG_DT_SAVE_ADDR);
      datatable_data <= has_save ? `CFG_DT_SAVE_SIZE : '0;
    end
  end

endmodule

`default_nettype wire

// ==== video_sync_shaper.sv ====
////////////////////
// sync shaping for the scaler
// hsync is delayed by CFG_HS_DELAY so it never lands on vsync
// vsync becomes a single cycle pulse on its rising edge
////////////////////

`default_nettype none

`include "core_cfg.svh"

module video_sync_shaper (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  video_hs_core,
  input  wire  video_vs_core,
  output logic video_hs,
  output logic video_vs
);

  logic                 hs_prev;
  logic                 vs_prev;
  video_pkg::hs_delay_t hs_delay;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_delay <= '0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      hs_prev <= video_hs_core;
      vs_prev <= video_vs_core;

      // fire on the last count
      video_hs <= (hs_delay == 3'd1);

      // a fresh rise reloads, even mid count
      if (video_hs_core && !hs_prev) begin
        hs_delay <= video_pkg::hs_delay_t'(`CFG_HS_DELAY);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 3'd1;
      end

      ////////////////////
      // vsync, no delay
      video_vs <= video_vs_core & ~vs_prev;
    end
  end

endmodule

`default_nettype wire

// ==== video_pixel_gate.sv ====
////////////////////
// data enable and pixel gating
// first blanked pixel after active video carries the slot word
////////////////////

`default_nettype none

`include "core_cfg.svh"

module video_pixel_gate (
  input  wire                  clk_74a,
  input  wire                  pll_core_locked,
  input  wire                  h_blank,
  input  wire                  v_blank,
  input  wire video_pkg::rgb_t video_rgb_core,
  input  wire                  hide_overscan,
  output logic                 video_de,
  output video_pkg::rgb_t      video_rgb
);

  logic            de;
  logic            de_prev;
  video_pkg::rgb_t slot_rgb;

  // active when neither blank is up
  assign de = ~(h_blank | v_blank);

  always_comb begin
    slot_rgb = '0;
    slot_rgb[`CFG_SLOT_HIDE_BIT] = hide_overscan;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev   <= 1'b0;
      video_de  <= 1'b0;
      video_rgb <= '0;
    end else begin
      de_prev  <= de;
      video_de <= de;
      if (de) begin
        video_rgb <= video_rgb_core;
      end else if (de_prev) begin
        // enable just fell
        video_rgb <= slot_rgb;
      end else begin
        video_rgb <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== apf_core_top.sv ====
////////////////////
// glue logic top for the console core wrapper
// settings, save-state start, data slot status and video out, all on clk_74a
////////////////////

`default_nettype none

module apf_core_top (
  input  wire                       clk_74a,
  input  wire                       pll_core_locked,

  // bridge writes
  input  wire bridge_pkg::bridge_addr_t bridge_addr,
  input  wire                       bridge_wr,
  input  wire bridge_pkg::bridge_data_t bridge_wr_data,

  // emulator settings
  output wire                       hide_overscan,
  output bridge_pkg::edge_mask_t    mask_vid_edges,
  output wire                       allow_extra_sprites,
  output bridge_pkg::palette_t      selected_palette,
  output wire                       multitap_enabled,

  // save-state start handshake
  input  wire                       savestate_start,
  output wire                       savestate_start_ack,
  output wire                       savestate_start_busy,
  output wire                       savestate_start_ok,

  // data slots
  input  wire                       dataslot_requestwrite,
  input  wire                       dataslot_allcomplete,
  input  wire                       has_save,
  output wire                       ioctl_download,
  output bridge_pkg::dt_addr_t      datatable_addr,
  output wire                       datatable_wren,
  output bridge_pkg::bridge_data_t  datatable_data,

  // video from the core, and to the scaler
  input  wire                       h_blank,
  input  wire                       v_blank,
  input  wire                       video_hs_core,
  input  wire                       video_vs_core,
  input  wire video_pkg::rgb_t      video_rgb_core,
  output wire                       video_de,
  output video_pkg::rgb_t           video_rgb,
  output wire                       video_hs,
  output wire                       video_vs
);

  bridge_settings_regs i_settings (
    .clk_74a            (clk_74a),
    .pll_core_locked    (pll_core_locked),
    .bridge_addr        (bridge_addr),
    .bridge_wr          (bridge_wr),
    .bridge_wr_data     (bridge_wr_data),
    .hide_overscan      (hide_overscan),
    .mask_vid_edges     (mask_vid_edges),
    .allow_extra_sprites(allow_extra_sprites),
    .selected_palette   (selected_palette),
    .multitap_enabled   (multitap_enabled)
  );

  savestate_start_responder i_ss_start (
    .clk_74a             (clk_74a),
    .pll_core_locked     (pll_core_locked),
    .savestate_start     (savestate_start),
    .savestate_start_ack (savestate_start_ack),
    .savestate_start_busy(savestate_start_busy),
    .savestate_start_ok  (savestate_start_ok)
  );

  dataslot_status i_dataslot (
    .clk_74a              (clk_74a),
    .pll_core_locked      (pll_core_locked),
    .dataslot_requestwrite(dataslot_requestwrite),
    .dataslot_allcomplete (dataslot_allcomplete),
    .has_save             (has_save),
    .ioctl_download       (ioctl_download),
    .datatable_addr       (datatable_addr),
    .datatable_wren       (datatable_wren),
    .datatable_data       (datatable_data)
  );

  ////////////////////
  // video
  video_sync_shaper i_sync (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .video_hs_core  (video_hs_core),
    .video_vs_core  (video_vs_core),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  // hide_overscan also feeds the slot word
  video_pixel_gate i_pixel (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .video_rgb_core (video_rgb_core),
    .hide_overscan  (hide_overscan),
    .video_de       (video_de),
    .video_rgb      (video_rgb)
  );

endmodule

`default_nettype wire

// ==== tb_apf_core_top.sv ====
////////////////////
// testbench for the glue logic top
// lfsr stimulus on every input, a cycle model of the rules,
// outputs compared on the falling edge
////////////////////

`default_nettype none

`include "core_cfg.svh"

module tb_apf_core_top;

  localparam int RESET_CYCLES  = 10;
  localparam int TEST_CYCLES   = 4000;
  localparam int CLK_PERIOD    = 20;
  localparam int WATCHDOG_TIME = (RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;
  // hs age meaning no rise seen recently
  localparam int HS_AGE_IDLE   = 255;

  // dut inputs, all start at 0
  logic                     clk_74a = 1'b0;
  logic                     pll_core_locked = 1'b0;
  bridge_pkg::bridge_addr_t bridge_addr = '0;
  logic                     bridge_wr = 1'b0;
  bridge_pkg::bridge_data_t bridge_wr_data = '0;
  logic                     savestate_start = 1'b0;
  logic                     dataslot_requestwrite = 1'b0;
  logic                     dataslot_allcomplete = 1'b0;
  logic                     has_save = 1'b0;
  logic                     h_blank = 1'b0;
  logic                     v_blank = 1'b0;
  logic                     video_hs_core = 1'b0;
  logic                     video_vs_core = 1'b0;
  video_pkg::rgb_t          video_rgb_core = '0;

  // dut outputs
  logic                     hide_overscan;
  bridge_pkg::edge_mask_t   mask_vid_edges;
  logic                     allow_extra_sprites;
  bridge_pkg::palette_t     selected_palette;
  logic                     multitap_enabled;
  logic                     savestate_start_ack;
  logic                     savestate_start_busy;
  logic                     savestate_start_ok;
  logic                     ioctl_download;
  bridge_pkg::dt_addr_t     datatable_addr;
  logic                     datatable_wren;
  bridge_pkg::bridge_data_t datatable_data;
  logic                     video_de;
  video_pkg::rgb_t          video_rgb;
  logic                     video_hs;
  logic                     video_vs;

  // model state, m_ mirrors the dut output of the same name
  logic                     m_hide;
  bridge_pkg::edge_mask_t   m_mask;
  logic                     m_sprites;
  bridge_pkg::palette_t     m_palette;
  logic                     m_multitap;
  logic                     m_ack;
  logic                     m_ok;
  int                       m_ss_left;
  logic                     m_start_prev;
  logic                     m_download;
  bridge_pkg::dt_addr_t     m_dt_addr;
  logic                     m_dt_wren;
  bridge_pkg::bridge_data_t m_dt_data;
  logic                     m_de;
  video_pkg::rgb_t          m_rgb;
  logic                     m_hs;
  int                       m_hs_age;
  logic                     m_hs_prev;
  logic                     m_vs;
  logic                     m_vs_prev;

  logic [31:0]              lfsr_state = 32'h7d65_bc73;

  apf_core_top i_dut (.*);

  always #(CLK_PERIOD / 2) clk_74a = ~clk_74a;

  ////////////////////
  // random numbers

  // galois step, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic bridge_pkg::bridge_addr_t setting_addr(input logic [31:0] idx);
    case (idx)
      32'd0:   return `CFG_ADDR_HIDE_OVERSCAN;
      32'd1:   return `CFG_ADDR_MASK_EDGES;
      32'd2:   return `CFG_ADDR_EXTRA_SPRITES;
      32'd3:   return `CFG_ADDR_PALETTE;
      default: return `CFG_ADDR_MULTITAP;
    endcase
  endfunction

  ////////////////////
  // stimulus, only once out of reset
  always @(posedge clk_74a) begin : stimulus
    logic [31:0] r;
    if (pll_core_locked) begin
      r = take_bits(1);
      bridge_wr <= r[0];
      // half the writes hit a settings register
      r = take_bits(1);
      if (r[0]) begin
        r = take_bits(3);
        bridge_addr <= setting_addr(r % 32'd5);
      end else begin
        bridge_addr <= take_bits(32);
      end
      bridge_wr_data <= take_bits(32);
      r = take_bits(2);
      if (r == 32'd0) savestate_start <= ~savestate_start;
      // single cycle pulses
      r = take_bits(4);
      dataslot_requestwrite <= (r == 32'd0) && !dataslot_requestwrite;
      r = take_bits(4);
      dataslot_allcomplete <= (r == 32'd0) && !dataslot_allcomplete;
      r = take_bits(5);
      if (r == 32'd0) has_save <= ~has_save;
      r = take_bits(2);
      if (r == 32'd0) h_blank <= ~h_blank;
      r = take_bits(5);
      if (r == 32'd0) v_blank <= ~v_blank;
      r = take_bits(3);
      if (r == 32'd0) video_hs_core <= ~video_hs_core;
      r = take_bits(3);
      if (r == 32'd0) video_vs_core <= ~video_vs_core;
      r = take_bits(24);
      video_rgb_core <= r[23:0];
    end
  end

  ////////////////////
  // cycle model, sees the inputs the dut samples on this edge
  always @(posedge clk_74a) begin : model
    logic de_in;
    de_in = ~(h_blank | v_blank);
    if (!pll_core_locked) begin
      m_hide       = 1'b0;
      m_mask       = '0;
      m_sprites    = 1'b0;
      m_palette    = '0;
      m_multitap   = 1'b0;
      m_ack        = 1'b0;
      m_ok         = 1'b0;
      m_ss_left    = 0;
      m_start_prev = 1'b0;
      m_download   = 1'b0;
      m_dt_addr    = '0;
      m_dt_wren    = 1'b0;
      m_dt_data    = '0;
      m_de         = 1'b0;
      m_rgb        = '0;
      m_hs         = 1'b0;
      m_hs_age     = HS_AGE_IDLE;
      m_hs_prev    = 1'b0;
      m_vs         = 1'b0;
      m_vs_prev    = 1'b0;
    end else begin
      // video first, slot word uses hide_overscan from before this edge
      if (de_in) begin
        m_rgb = video_rgb_core;
      end else if (m_de) begin
        m_rgb = '0;
        m_rgb[`CFG_SLOT_HIDE_BIT] = m_hide;
      end else begin
        m_rgb = '0;
      end
      m_de = de_in;
      // hs fires on E7, counted as edges since the last rise
      m_hs = (m_hs_age == `CFG_HS_DELAY - 1);
      if (video_hs_core && !m_hs_prev) m_hs_age = 0;
      else if (m_hs_age < HS_AGE_IDLE) m_hs_age++;
      m_hs_prev = video_hs_core;
      m_vs      = video_vs_core & ~m_vs_prev;
      m_vs_prev = video_vs_core;

      if (bridge_wr) begin
        case (bridge_addr)
          `CFG_ADDR_HIDE_OVERSCAN: m_hide     = bridge_wr_data[0];
          `CFG_ADDR_MASK_EDGES:    m_mask     = bridge_wr_data[1:0];
          `CFG_ADDR_EXTRA_SPRITES: m_sprites  = bridge_wr_data[0];
          `CFG_ADDR_PALETTE:       m_palette  = bridge_wr_data[2:0];
          `CFG_ADDR_MULTITAP:      m_multitap = bridge_wr_data[0];
          default: ;
        endcase
      end

      // busy for E0 and E1, ok from E2
      m_ack = 1'b0;
      if (m_ss_left > 0) begin
        m_ss_left--;
        if (m_ss_left == 0) m_ok = 1'b1;
      end else if (savestate_start && !m_start_prev) begin
        m_ss_left = `CFG_SS_HOLD;
        m_ack     = 1'b1;
        m_ok      = 1'b0;
      end
      m_start_prev = savestate_start;

      if (dataslot_requestwrite) m_download = 1'b1;
      else if (dataslot_allcomplete) m_download = 1'b0;
      m_dt_wren = 1'b1;
      m_dt_addr = bridge_pkg::dt_addr_t'(`CFG_DT_SAVE_ADDR);
      m_dt_data = has_save ? `CFG_DT_SAVE_SIZE : 32'd0;
    end
  end

  ////////////////////
  // checks
  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk_74a) begin
    compare("hide_overscan", 32'(hide_overscan), 32'(m_hide));
    compare("mask_vid_edges", 32'(mask_vid_edges), 32'(m_mask));
    compare("allow_extra_sprites", 32'(allow_extra_sprites), 32'(m_sprites));
    compare("selected_palette", 32'(selected_palette), 32'(m_palette));
    compare("multitap_enabled", 32'(multitap_enabled), 32'(m_multitap));
    compare("savestate_start_ack", 32'(savestate_start_ack), 32'(m_ack));
    compare("savestate_start_busy", 32'(savestate_start_busy), 32'(m_ss_left > 0));
    compare("savestate_start_ok", 32'(savestate_start_ok), 32'(m_ok));
    compare("ioctl_download", 32'(ioctl_download), 32'(m_download));
    compare("datatable_addr", 32'(datatable_addr), 32'(m_dt_addr));
    compare("datatable_wren", 32'(datatable_wren), 32'(m_dt_wren));
    compare("datatable_data", datatable_data, m_dt_data);
    compare("video_de", 32'(video_de), 32'(m_de));
    compare("video_rgb", 32'(video_rgb), 32'(m_rgb));
    compare("video_hs", 32'(video_hs), 32'(m_hs));
    compare("video_vs", 32'(video_vs), 32'(m_vs));
  end

  ////////////////////
  // run control
  initial begin
    repeat (RESET_CYCLES) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    repeat (TEST_CYCLES) @(posedge clk_74a);
    // let the last falling edge check finish
    @(negedge clk_74a);
    #1;
    $display("Test OK");
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before the run reached its end");
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
bridge_pkg.sv
video_pkg.sv
bridge_settings_regs.sv
savestate_start_responder.sv
dataslot_status.sv
video_sync_shaper.sv
video_pixel_gate.sv
apf_core_top.sv
tb_apf_core_top.sv

// ==== Makefile ====
# Verilator flow for the core wrapper glue logic
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_apf_core_top
LINT_TOP  ?= apf_core_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
